/* design/serdes_word_pkg.sv */
`default_nettype none

package serdes_word_pkg;

	localparam int WORD_WIDTH = 8; // bits per serialized word

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [1:0] pattern_idx_t;

	// line idles high
	localparam word_t IDLE_WORD = ~word_t'(0);

	localparam word_t PATTERN_FIRST  = ~8'b11111111;
	localparam word_t PATTERN_SECOND = ~8'b11110001;
	localparam word_t PATTERN_THIRD  = ~8'b10001000;
	localparam word_t PATTERN_FOURTH = ~8'b10101010;

	// word handed from arbiter to serializer
	typedef struct packed {
		word_t        word;
		logic         valid;
		pattern_idx_t idx;
	} slot_word_t;

	function automatic word_t pattern_word(input pattern_idx_t idx);
		word_t w;
		case (idx)
			2'd0:    w = PATTERN_FIRST;
			2'd1:    w = PATTERN_SECOND;
			2'd2:    w = PATTERN_THIRD;
			default: w = PATTERN_FOURTH;
		endcase
		return w;
	endfunction

endpackage

`default_nettype wire

/* design/trig_ctrl_pkg.sv */
`default_nettype none

package trig_ctrl_pkg;

	// who owns the current word slot
	typedef enum logic [1:0] {
		GRANT_NONE  = 2'd0,
		GRANT_EXT   = 2'd1,
		GRANT_TIMER = 2'd2
	} grant_src_t;

	// control inputs after synchronization
	typedef struct packed {
		logic trig_edge; // one-cycle pulse per external trigger
		logic self_mode; // level from the mode switch
	} ctrl_in_t;

endpackage

`default_nettype wire

/* design/trigger_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_sync (
	input  wire  other_clock,
	input  wire  reset1,
	input  logic trig_in,
	output logic trig_edge
);

	logic [2:0] sync_q; // sync_q[0] is the metastable stage
	logic       last_q;

	always_ff @(posedge other_clock) begin
		if (reset1) begin
			sync_q <= '0;
			last_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[1:0], trig_in};
			last_q <= sync_q[2];
		end
	end

	// rising edge of the synchronized level
	assign trig_edge = sync_q[2] & ~last_q;

endmodule

`default_nettype wire

/* design/pattern_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_sequencer (
	input  wire                           other_clock,
	input  wire                           reset1,
	input  trig_ctrl_pkg::ctrl_in_t       ctrl,
	input  logic                          ext_grant,
	output logic                          ext_req,
	output serdes_word_pkg::pattern_idx_t ext_idx,
	output logic                          ext_drop
);

	logic edge_dropped;

	// an edge is lost only if the earlier request is still waiting
	assign edge_dropped = ctrl.trig_edge & ext_req & ~ext_grant;

	always_ff @(posedge other_clock) begin
		if (reset1) begin
			ext_req  <= 1'b0;
			ext_idx  <= '0;
			ext_drop <= 1'b0;
		end else begin
			ext_drop <= edge_dropped;
			if (ext_grant) begin
				ext_req <= 1'b0;
				ext_idx <= ext_idx + 1'b1; // token wraps after the fourth word
			end
			if (ctrl.trig_edge && !edge_dropped) begin
				ext_req <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/self_trigger_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module self_trigger_timer #(
	parameter int PICKOFF = 24
) (
	input  wire                           other_clock,
	input  wire                           reset1,
	input  trig_ctrl_pkg::ctrl_in_t       ctrl,
	input  logic                          slot_strobe,
	input  logic                          tmr_grant,
	output logic                          tmr_req,
	output serdes_word_pkg::pattern_idx_t tmr_idx
);

	logic [PICKOFF-1:0] slot_cnt;
	logic               wrap;

	assign wrap = slot_strobe & (&slot_cnt);

	always_ff @(posedge other_clock) begin
		if (reset1) begin
			slot_cnt <= '0;
			tmr_req  <= 1'b0;
			tmr_idx  <= '0;
		end else begin
			if (slot_strobe) begin
				slot_cnt <= slot_cnt + 1'b1;
			end
			if (tmr_grant) begin
				tmr_req <= 1'b0;
				tmr_idx <= tmr_idx + 1'b1;
			end
			// a wrap with a request still pending is simply lost
			if (wrap && ctrl.self_mode && (!tmr_req || tmr_grant)) begin
				tmr_req <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/word_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module word_arbiter #(
	parameter int WIDTH = serdes_word_pkg::WORD_WIDTH
) (
	input  logic                          slot_strobe,
	input  logic                          ext_req,
	input  serdes_word_pkg::pattern_idx_t ext_idx,
	input  logic                          tmr_req,
	input  serdes_word_pkg::pattern_idx_t tmr_idx,
	output logic                          ext_grant,
	output logic                          tmr_grant,
	output serdes_word_pkg::slot_word_t   slot_word,
	output trig_ctrl_pkg::grant_src_t     slot_src
);

	serdes_word_pkg::pattern_idx_t sel_idx;
	logic [WIDTH-1:0]              sel_word;
	logic                          granted;

	// external trigger always wins
	always_comb begin
		ext_grant = 1'b0;
		tmr_grant = 1'b0;
		slot_src  = trig_ctrl_pkg::GRANT_NONE;
		sel_idx   = '0;
		if (slot_strobe) begin
			if (ext_req) begin
				ext_grant = 1'b1;
				slot_src  = trig_ctrl_pkg::GRANT_EXT;
				sel_idx   = ext_idx;
			end else if (tmr_req) begin
				tmr_grant = 1'b1;
				slot_src  = trig_ctrl_pkg::GRANT_TIMER;
				sel_idx   = tmr_idx;
			end
		end
	end

	assign granted  = (slot_src != trig_ctrl_pkg::GRANT_NONE);
	assign sel_word = granted ? serdes_word_pkg::pattern_word(sel_idx) : {WIDTH{1'b1}};

	always_comb begin
		slot_word.word  = sel_word;
		slot_word.valid = granted;
		slot_word.idx   = sel_idx;
	end

endmodule

`default_nettype wire

/* design/word_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module word_serializer #(
	parameter int WIDTH = serdes_word_pkg::WORD_WIDTH
) (
	input  wire                         other_clock,
	input  wire                         reset1,
	input  serdes_word_pkg::slot_word_t slot_word,
	input  trig_ctrl_pkg::grant_src_t   slot_src,
	output logic                        slot_strobe,
	output logic                        word_start,
	output logic                        d_out,
	output logic                        t_out,
	output logic                        sync
);

	localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(WIDTH - 1);

	logic [CNT_W-1:0] slot_cnt;
	logic [WIDTH-1:0] d_sr;
	logic [WIDTH-1:0] t_sr;
	logic [WIDTH-1:0] d_load;
	logic [WIDTH-1:0] t_load;
	logic             ext_word;

	assign slot_strobe = (slot_cnt == LAST_BIT); // last cycle of the slot

	assign ext_word = slot_word.valid && (slot_src == trig_ctrl_pkg::GRANT_EXT);
	assign d_load   = slot_word.valid ? slot_word.word : serdes_word_pkg::IDLE_WORD;
	assign t_load   = ext_word ? slot_word.word : serdes_word_pkg::IDLE_WORD;

	always_ff @(posedge other_clock) begin
		if (reset1) begin
			slot_cnt   <= '0;
			word_start <= 1'b0;
			d_sr       <= '1;
			t_sr       <= '1;
			sync       <= 1'b0;
		end else begin
			word_start <= slot_strobe;
			if (slot_strobe) begin
				slot_cnt <= '0;
				d_sr     <= d_load;
				t_sr     <= t_load;
				if (slot_word.valid) begin
					if (slot_word.idx == serdes_word_pkg::pattern_idx_t'(0)) begin
						sync <= 1'b1;
					end else if (slot_word.idx == serdes_word_pkg::pattern_idx_t'(1)) begin
						sync <= 1'b0;
					end
				end
			end else begin
				slot_cnt <= slot_cnt + 1'b1;
				d_sr     <= {d_sr[WIDTH-2:0], 1'b1}; // msb first, back-fill idle
				t_sr     <= {t_sr[WIDTH-2:0], 1'b1};
			end
		end
	end

	assign d_out = d_sr[WIDTH-1];
	assign t_out = t_sr[WIDTH-1];

endmodule

`default_nettype wire

/* design/trigger_gen_top.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_gen_top #(
	parameter int WIDTH   = serdes_word_pkg::WORD_WIDTH,
	parameter int PICKOFF = 24
) (
	input  wire  other_clock,
	input  wire  reset1,
	input  logic trig_in,
	input  logic self_mode,
	output logic d_out,
	output logic t_out,
	output logic sync,
	output logic word_start,
	output logic drop_pulse
);

	trig_ctrl_pkg::ctrl_in_t       ctrl;
	trig_ctrl_pkg::grant_src_t     slot_src;
	serdes_word_pkg::slot_word_t   slot_word;
	serdes_word_pkg::pattern_idx_t ext_idx;
	serdes_word_pkg::pattern_idx_t tmr_idx;
	logic                          trig_edge;
	logic                          slot_strobe;
	logic                          ext_req;
	logic                          ext_grant;
	logic                          tmr_req;
	logic                          tmr_grant;

	trigger_sync u_sync (
		.other_clock (other_clock),
		.reset1      (reset1),
		.trig_in     (trig_in),
		.trig_edge   (trig_edge)
	);

	assign ctrl.trig_edge = trig_edge;
	assign ctrl.self_mode = self_mode; // switch is quasi-static

	pattern_sequencer u_seq (
		.other_clock (other_clock),
		.reset1      (reset1),
		.ctrl        (ctrl),
		.ext_grant   (ext_grant),
		.ext_req     (ext_req),
		.ext_idx     (ext_idx),
		.ext_drop    (drop_pulse)
	);

	self_trigger_timer #(.PICKOFF(PICKOFF)) u_timer (
		.other_clock (other_clock),
		.reset1      (reset1),
		.ctrl        (ctrl),
		.slot_strobe (slot_strobe),
		.tmr_grant   (tmr_grant),
		.tmr_req     (tmr_req),
		.tmr_idx     (tmr_idx)
	);

	word_arbiter #(.WIDTH(WIDTH)) u_arb (
		.slot_strobe (slot_strobe),
		.ext_req     (ext_req),
		.ext_idx     (ext_idx),
		.tmr_req     (tmr_req),
		.tmr_idx     (tmr_idx),
		.ext_grant   (ext_grant),
		.tmr_grant   (tmr_grant),
		.slot_word   (slot_word),
		.slot_src    (slot_src)
	);

	word_serializer #(.WIDTH(WIDTH)) u_ser (
		.other_clock (other_clock),
		.reset1      (reset1),
		.slot_word   (slot_word),
		.slot_src    (slot_src),
		.slot_strobe (slot_strobe),
		.word_start  (word_start),
		.d_out       (d_out),
		.t_out       (t_out),
		.sync        (sync)
	);

endmodule

`default_nettype wire

/* verif/trigger_gen_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_gen_assert (
	input wire  other_clock,
	input wire  reset1,
	input logic ext_grant,
	input logic tmr_grant,
	input logic slot_strobe,
	input logic word_start
);

	// at most one peer owns a slot
	grant_onehot: assert property (@(posedge other_clock) disable iff (reset1)
		$onehot0({ext_grant, tmr_grant}))
		else $error("both peers granted in the same cycle");

	grant_on_strobe: assert property (@(posedge other_clock) disable iff (reset1)
		(ext_grant || tmr_grant) |-> slot_strobe)
		else $error("grant outside the slot strobe");

	start_after_strobe: assert property (@(posedge other_clock) disable iff (reset1)
		slot_strobe |=> word_start)
		else $error("word_start missing after slot_strobe");

endmodule

// nets between arbiter and serializer
bind trigger_gen_top trigger_gen_assert arb_ser_checks (
	.other_clock (other_clock),
	.reset1      (reset1),
	.ext_grant   (ext_grant),
	.tmr_grant   (tmr_grant),
	.slot_strobe (slot_strobe),
	.word_start  (word_start)
);

`default_nettype wire

/* verif/trigger_gen_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_gen_tb;

	localparam int WIDTH         = serdes_word_pkg::WORD_WIDTH;
	localparam int PICKOFF       = 3;
	localparam int START_TIMEOUT = 4 * WIDTH; // cycles to wait for a slot boundary

	localparam serdes_word_pkg::word_t IDLE_LINE = '1; // line idles high

	logic other_clock = 1'b0;
	logic reset1;
	logic trig_in;
	logic self_mode;
	logic d_out;
	logic t_out;
	logic sync;
	logic word_start;
	logic drop_pulse;

	string  cur_test;
	int     test_errors;
	int     total_errors;
	int     tests_run;
	int     tests_failed;
	int     drop_total = 0;
	integer seed;

	trigger_gen_top #(.WIDTH(WIDTH), .PICKOFF(PICKOFF)) dut0 (
		.other_clock (other_clock),
		.reset1      (reset1),
		.trig_in     (trig_in),
		.self_mode   (self_mode),
		.d_out       (d_out),
		.t_out       (t_out),
		.sync        (sync),
		.word_start  (word_start),
		.drop_pulse  (drop_pulse)
	);

	always #4 other_clock = ~other_clock;

	always @(posedge other_clock) begin
		if (drop_pulse === 1'b1) begin
			drop_total <= drop_total + 1;
		end
	end

	// four-word cycle, each the inverse of its raw pattern
	function automatic serdes_word_pkg::word_t cycle_word(input int idx);
		serdes_word_pkg::word_t w;
		case (idx % 4)
			0:       w = ~8'b11111111;
			1:       w = ~8'b11110001;
			2:       w = ~8'b10001000;
			default: w = ~8'b10101010;
		endcase
		return w;
	endfunction

	function automatic logic sync_after(input logic cur, input int idx);
		logic s;
		s = cur;
		if (idx % 4 == 0) begin
			s = 1'b1;
		end else if (idx % 4 == 1) begin
			s = 1'b0;
		end
		return s;
	endfunction

	task automatic check_word(input string what, input serdes_word_pkg::word_t exp,
			input serdes_word_pkg::word_t act);
		if (act !== exp) begin
			$display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_sync(input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error: %s sync expected %b actual %b", cur_test, exp, act);
			test_errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errors++;
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", cur_test, test_errors);
		end
	endtask

	task automatic apply_reset(input logic mode);
		@(posedge other_clock);
		reset1    <= 1'b1;
		trig_in   <= 1'b0;
		self_mode <= mode;
		repeat (10) @(posedge other_clock);
		reset1 <= 1'b0;
	endtask

	task automatic wait_word_start();
		int n;
		n = 0;
		@(negedge other_clock);
		while (word_start !== 1'b1 && n < START_TIMEOUT) begin
			@(negedge other_clock);
			n++;
		end
		if (word_start !== 1'b1) begin
			note_failure("timed out waiting for word_start");
		end
	endtask

	// one slot of both lanes, msb arrives with word_start
	task automatic capture_slot(output serdes_word_pkg::word_t d_w,
			output serdes_word_pkg::word_t t_w, output logic s);
		wait_word_start();
		s = sync;
		for (int i = WIDTH - 1; i >= 0; i--) begin
			if (i != WIDTH - 1) begin
				@(negedge other_clock);
			end
			d_w[i] = d_out;
			t_w[i] = t_out;
		end
	endtask

	task automatic send_trigger();
		@(posedge other_clock);
		trig_in <= 1'b1;
		repeat (2) @(posedge other_clock);
		trig_in <= 1'b0;
	endtask

	task automatic await_pattern(input int idx, inout logic exp_sync);
		serdes_word_pkg::word_t d_w;
		serdes_word_pkg::word_t t_w;
		logic                   s;
		int                     n;
		bit                     found;
		found = 1'b0;
		n     = 0;
		while (!found && n < 4) begin
			capture_slot(d_w, t_w, s);
			found = (d_w !== IDLE_LINE);
			n++;
		end
		if (!found) begin
			note_failure("no pattern word within four slots");
		end else begin
			exp_sync = sync_after(exp_sync, idx);
			check_word("d word", cycle_word(idx), d_w);
			check_word("t word", cycle_word(idx), t_w);
			check_sync(exp_sync, s);
			capture_slot(d_w, t_w, s); // one word per trigger
			check_word("d after word", IDLE_LINE, d_w);
		end
	endtask

	task automatic test_idle();
		serdes_word_pkg::word_t d_w;
		serdes_word_pkg::word_t t_w;
		logic                   s;
		begin_test("idle");
		apply_reset(1'b0);
		repeat (4) begin
			capture_slot(d_w, t_w, s);
			check_word("d", IDLE_LINE, d_w);
			check_word("t", IDLE_LINE, t_w);
			check_sync(1'b0, s);
		end
		end_test();
	endtask

	task automatic test_ext_cycle();
		logic exp_sync;
		int   drops0;
		begin_test("ext_cycle");
		apply_reset(1'b0);
		exp_sync = 1'b0;
		drops0   = drop_total;
		for (int k = 0; k < 6; k++) begin
			repeat (2 * WIDTH) @(posedge other_clock);
			send_trigger();
			await_pattern(k, exp_sync);
		end
		if (drop_total != drops0) begin
			note_failure("drop pulse seen with widely spaced triggers");
		end
		end_test();
	endtask

	task automatic test_self_mode();
		serdes_word_pkg::word_t d_w;
		serdes_word_pkg::word_t t_w;
		logic                   s;
		logic                   exp_sync;
		int                     seen;
		int                     last_slot;
		begin_test("self_mode");
		apply_reset(1'b1);
		exp_sync  = 1'b0;
		seen      = 0;
		last_slot = -1;
		for (int slot = 1; slot <= 36; slot++) begin
			capture_slot(d_w, t_w, s);
			check_word("t", IDLE_LINE, t_w);
			if (d_w !== IDLE_LINE) begin
				check_word("d", cycle_word(seen), d_w);
				if (last_slot >= 0 && slot - last_slot != 2 ** PICKOFF) begin
					note_failure($sformatf("timer words came %0d slots apart",
						slot - last_slot));
				end
				last_slot = slot;
				exp_sync  = sync_after(exp_sync, seen);
				seen++;
			end
			check_sync(exp_sync, s);
		end
		if (seen < 4) begin
			note_failure($sformatf("only %0d timer words in 36 slots", seen));
		end
		end_test();
	endtask

	task automatic test_priority();
		serdes_word_pkg::word_t d_w;
		serdes_word_pkg::word_t t_w;
		logic                   s;
		begin_test("priority");
		apply_reset(1'b1);
		repeat (2 ** PICKOFF - 1) begin
			capture_slot(d_w, t_w, s);
			check_word("d before wrap", IDLE_LINE, d_w);
		end
		// timer request is pending through this slot
		wait_word_start();
		send_trigger();
		capture_slot(d_w, t_w, s);
		check_word("d ext word", cycle_word(0), d_w);
		check_word("t ext word", cycle_word(0), t_w);
		capture_slot(d_w, t_w, s);
		check_word("d timer word", cycle_word(0), d_w);
		check_word("t timer word", IDLE_LINE, t_w);
		end_test();
	endtask

	task automatic test_drop();
		serdes_word_pkg::word_t d_w;
		serdes_word_pkg::word_t t_w;
		logic                   s;
		int                     drops0;
		int                     words;
		begin_test("drop");
		apply_reset(1'b0);
		drops0 = drop_total;
		words  = 0;
		wait_word_start();
		@(posedge other_clock);
		trig_in <= 1'b1;
		@(posedge other_clock);
		trig_in <= 1'b0;
		@(posedge other_clock);
		trig_in <= 1'b1; // second edge while the first is still pending
		@(posedge other_clock);
		trig_in <= 1'b0;
		repeat (4) begin
			capture_slot(d_w, t_w, s);
			if (d_w !== IDLE_LINE) begin
				if (words == 0) begin
					check_word("d word", cycle_word(0), d_w);
				end
				words++;
			end
		end
		if (drop_total - drops0 != 1) begin
			note_failure($sformatf("wanted one drop pulse but saw %0d", drop_total - drops0));
		end
		if (words != 1) begin
			note_failure($sformatf("wanted one pattern word but saw %0d", words));
		end
		end_test();
	endtask

	task automatic test_random_gaps();
		logic exp_sync;
		int   drops0;
		int   gap;
		begin_test("random_gaps");
		apply_reset(1'b0);
		exp_sync = 1'b0;
		drops0   = drop_total;
		for (int k = 0; k < 10; k++) begin
			gap = 3 * WIDTH + ($unsigned($random(seed)) % (2 * WIDTH));
			repeat (gap) @(posedge other_clock);
			send_trigger();
			await_pattern(k, exp_sync);
		end
		if (drop_total != drops0) begin
			note_failure("drop pulse seen with spaced triggers");
		end
		end_test();
	endtask

	initial begin
		reset1       = 1'b1;
		trig_in      = 1'b0;
		self_mode    = 1'b0;
		seed         = 25486;
		total_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_idle();
		test_ext_cycle();
		test_self_mode();
		test_priority();
		test_drop();
		test_random_gaps();
		$display("summary: %0d tests, %0d failed, %0d errors",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
design/serdes_word_pkg.sv
design/trig_ctrl_pkg.sv
design/trigger_sync.sv
design/pattern_sequencer.sv
design/self_trigger_timer.sv
design/word_arbiter.sv
design/word_serializer.sv
design/trigger_gen_top.sv
verif/trigger_gen_assert.sv
verif/trigger_gen_tb.sv

/* Bender.yml */
package:
  name: trigger_gen

sources:
  - design/serdes_word_pkg.sv
  - design/trig_ctrl_pkg.sv
  - design/trigger_sync.sv
  - design/pattern_sequencer.sv
  - design/self_trigger_timer.sv
  - design/word_arbiter.sv
  - design/word_serializer.sv
  - design/trigger_gen_top.sv
  - target: test
    files:
      - verif/trigger_gen_assert.sv
      - verif/trigger_gen_tb.sv
